/* fe_pkg.sv */
package fe_pkg;

    ////////////////////
    // Lane and datapath widths

    // Fetch and issue lanes, one FIFO bank per lane
    localparam int LANES = 2;

    // PC and instruction word
    localparam int XLEN = 32;

    // Reduced exception cause per lane
    localparam int EXC_W = 6;

    // Code for a lane with no fault
    localparam logic [EXC_W-1:0] EXC_NONE = '0;

    ////////////////////
    // Bank geometry

    // Entries per bank, kept a power of two
    localparam int DEPTH = 8;
    localparam int PTR_W = $clog2(DEPTH);

    ////////////////////
    // Entry layout, LSB first

    localparam int PC_LSB    = 0;
    localparam int INST_LSB  = PC_LSB + XLEN;
    localparam int EXC_LSB   = INST_LSB + XLEN;
    localparam int BR_BIT    = EXC_LSB + EXC_W;
    localparam int TAKEN_BIT = BR_BIT + 1;
    localparam int TGT_LSB   = TAKEN_BIT + 1;

    // Low means wrong path behind a predicted-taken branch
    localparam int VALID_BIT = TGT_LSB + XLEN;

    // 32 + 32 + 6 + 1 + 1 + 32 + 1 = 105
    localparam int ENTRY_W = VALID_BIT + 1;

endpackage

/* fetch_capture.sv */
`timescale 1ns/1ps

module fetch_capture (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          flush_i,
    input  logic                                          stall_i,
    input  logic [fe_pkg::LANES-1:0]                      fetch_en_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]    pc_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]    inst_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0]   exc_i,
    input  logic [fe_pkg::LANES-1:0]                      is_branch_i,
    input  logic [fe_pkg::LANES-1:0]                      pred_taken_i,
    input  logic [fe_pkg::XLEN-1:0]                       pred_target_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::PTR_W:0]     free_slots_i,
    output logic                                          fetch_ready_o,
    output logic [fe_pkg::LANES-1:0]                      push_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::ENTRY_W-1:0] push_data_o
);

    logic                                          live_q;
    logic                                          shadow_q;
    logic [fe_pkg::LANES-1:0]                      room_ok;
    logic [fe_pkg::LANES-1:0]                      accept;
    logic [fe_pkg::LANES-1:0]                      taken;
    logic [fe_pkg::LANES-1:0]                      behind_taken;
    logic [fe_pkg::LANES-1:0][fe_pkg::ENTRY_W-1:0] entry;

    ////////////////////
    // Back-pressure and acceptance

    // Two free slots per bank, one more if an entry is still in flight
    always_comb begin
        for (int b = 0; b < fe_pkg::LANES; b++) begin
            room_ok[b] = free_slots_i[b] >= (fe_pkg::PTR_W + 1)'(push_o[b] ? 3 : 2);
        end
    end

    assign fetch_ready_o = live_q & (&room_ok);

    // Fetch-side inputs are ignored during flush
    assign accept = fetch_en_i & {fe_pkg::LANES{fetch_ready_o & ~stall_i & ~flush_i}};
    assign taken  = accept & is_branch_i & pred_taken_i;

    ////////////////////
    // Branch shadow

    // Lane i is wrong path if the last group or an earlier lane was taken
    always_comb begin
        behind_taken[0] = shadow_q;
        for (int i = 1; i < fe_pkg::LANES; i++) begin
            behind_taken[i] = behind_taken[i-1] | taken[i-1];
        end
    end

    // Pack each lane into its bank entry
    always_comb begin
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            entry[i] = '0;
            entry[i][fe_pkg::PC_LSB +: fe_pkg::XLEN]    = pc_i[i];
            entry[i][fe_pkg::INST_LSB +: fe_pkg::XLEN]  = inst_i[i];
            entry[i][fe_pkg::EXC_LSB +: fe_pkg::EXC_W]  = exc_i[i];
            entry[i][fe_pkg::BR_BIT]                    = is_branch_i[i];
            entry[i][fe_pkg::TAKEN_BIT]                 = pred_taken_i[i];
            entry[i][fe_pkg::TGT_LSB +: fe_pkg::XLEN]   = pred_target_i;
            entry[i][fe_pkg::VALID_BIT]                 = ~behind_taken[i];
        end
    end

    ////////////////////
    // Capture register

    always_ff @(posedge clk) begin
        if (rst) begin
            live_q   <= 1'b0;
            shadow_q <= 1'b0;
            push_o   <= '0;
        end else begin
            live_q <= 1'b1;
            push_o <= accept;
            if (flush_i) begin
                shadow_q <= 1'b0;
            end else if (|accept) begin
                // Group history only moves on an accepted group
                shadow_q <= |taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            push_data_o[i] <= accept[i] ? entry[i] : '0;
        end
    end

endmodule

/* inst_fifo.sv */
`timescale 1ns/1ps

module inst_fifo (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush_i,
    input  logic                       push_i,
    input  logic [fe_pkg::ENTRY_W-1:0] push_data_i,
    input  logic                       pop_i,
    output logic [fe_pkg::ENTRY_W-1:0] head_o,
    output logic                       empty_o,
    output logic [fe_pkg::PTR_W:0]     free_slots_o
);

    logic [fe_pkg::ENTRY_W-1:0] mem [fe_pkg::DEPTH];
    logic [fe_pkg::PTR_W-1:0]   wr_ptr;
    logic [fe_pkg::PTR_W-1:0]   rd_ptr;
    logic [fe_pkg::PTR_W:0]     count;
    logic                       full;
    logic                       do_push;
    logic                       do_pop;

    // Wrap at the last slot
    function automatic logic [fe_pkg::PTR_W-1:0] next_ptr(
        input logic [fe_pkg::PTR_W-1:0] ptr
    );
        if (ptr == fe_pkg::PTR_W'(fe_pkg::DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = count == (fe_pkg::PTR_W + 1)'(fe_pkg::DEPTH);
    assign empty_o = count == '0;

    // A full bank still takes a push when the head leaves in the same cycle
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full | do_pop);

    ////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Show-ahead head entry
    assign head_o = mem[rd_ptr];

    assign free_slots_o = (fe_pkg::PTR_W + 1)'(fe_pkg::DEPTH) - count;

endmodule

/* issue_select.sv */
`timescale 1ns/1ps

module issue_select (
    input  logic                                          stall_i,
    input  logic [fe_pkg::LANES-1:0]                      send_en_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::ENTRY_W-1:0] head_i,
    input  logic [fe_pkg::LANES-1:0]                      empty_i,
    output logic [fe_pkg::LANES-1:0]                      pop_o,
    output logic [fe_pkg::LANES-1:0]                      issue_valid_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]    issue_pc_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]    issue_inst_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0]   issue_exc_o,
    output logic [fe_pkg::LANES-1:0]                      issue_is_branch_o,
    output logic [fe_pkg::LANES-1:0]                      issue_pred_taken_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]    issue_pred_target_o,
    output logic [fe_pkg::LANES-1:0]                      issue_slot_valid_o
);

    logic [fe_pkg::LANES-1:0] fire;

    // Each lane issues on its own send enable
    assign fire = send_en_i & ~empty_i & {fe_pkg::LANES{~stall_i}};

    // Head leaves its bank at the edge ending the issue cycle
    assign pop_o         = fire;
    assign issue_valid_o = fire;

    ////////////////////
    // Unpack head entries

    always_comb begin
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            if (fire[i]) begin
                issue_pc_o[i]          = head_i[i][fe_pkg::PC_LSB +: fe_pkg::XLEN];
                issue_inst_o[i]        = head_i[i][fe_pkg::INST_LSB +: fe_pkg::XLEN];
                issue_exc_o[i]         = head_i[i][fe_pkg::EXC_LSB +: fe_pkg::EXC_W];
                issue_is_branch_o[i]   = head_i[i][fe_pkg::BR_BIT];
                issue_pred_taken_o[i]  = head_i[i][fe_pkg::TAKEN_BIT];
                issue_pred_target_o[i] = head_i[i][fe_pkg::TGT_LSB +: fe_pkg::XLEN];
                issue_slot_valid_o[i]  = head_i[i][fe_pkg::VALID_BIT];
            end else begin
                // Idle lane shows zeros to decode
                issue_pc_o[i]          = '0;
                issue_inst_o[i]        = '0;
                issue_exc_o[i]         = '0;
                issue_is_branch_o[i]   = 1'b0;
                issue_pred_taken_o[i]  = 1'b0;
                issue_pred_target_o[i] = '0;
                issue_slot_valid_o[i]  = 1'b0;
            end
        end
    end

endmodule

/* inst_buffer_top.sv */
`timescale 1ns/1ps

module inst_buffer_top (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        flush_i,
    input  logic                                        stall_i,
    // Fetch side
    input  logic [fe_pkg::LANES-1:0]                    fetch_en_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  pc_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  inst_i,
    input  logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0] exc_i,
    input  logic [fe_pkg::LANES-1:0]                    is_branch_i,
    input  logic [fe_pkg::LANES-1:0]                    pred_taken_i,
    input  logic [fe_pkg::XLEN-1:0]                     pred_target_i,
    output logic                                        fetch_ready_o,
    // Decode side
    input  logic [fe_pkg::LANES-1:0]                    send_en_i,
    output logic [fe_pkg::LANES-1:0]                    issue_valid_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_pc_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_inst_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0] issue_exc_o,
    output logic [fe_pkg::LANES-1:0]                    issue_is_branch_o,
    output logic [fe_pkg::LANES-1:0]                    issue_pred_taken_o,
    output logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_pred_target_o,
    output logic [fe_pkg::LANES-1:0]                    issue_slot_valid_o
);

    logic [fe_pkg::LANES-1:0]                      push;
    logic [fe_pkg::LANES-1:0][fe_pkg::ENTRY_W-1:0] push_data;
    logic [fe_pkg::LANES-1:0][fe_pkg::PTR_W:0]     free_slots;
    logic [fe_pkg::LANES-1:0][fe_pkg::ENTRY_W-1:0] head;
    logic [fe_pkg::LANES-1:0]                      empty;
    logic [fe_pkg::LANES-1:0]                      pop;

    fetch_capture u_capture (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .stall_i       (stall_i),
        .fetch_en_i    (fetch_en_i),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .exc_i         (exc_i),
        .is_branch_i   (is_branch_i),
        .pred_taken_i  (pred_taken_i),
        .pred_target_i (pred_target_i),
        .free_slots_i  (free_slots),
        .fetch_ready_o (fetch_ready_o),
        .push_o        (push),
        .push_data_o   (push_data)
    );

    ////////////////////
    // One bank per lane

    for (genvar i = 0; i < fe_pkg::LANES; i++) begin : gen_bank
        inst_fifo u_fifo (
            .clk          (clk),
            .rst          (rst),
            .flush_i      (flush_i),
            .push_i       (push[i]),
            .push_data_i  (push_data[i]),
            .pop_i        (pop[i]),
            .head_o       (head[i]),
            .empty_o      (empty[i]),
            .free_slots_o (free_slots[i])
        );
    end

    issue_select u_issue (
        .stall_i             (stall_i),
        .send_en_i           (send_en_i),
        .head_i              (head),
        .empty_i             (empty),
        .pop_o               (pop),
        .issue_valid_o       (issue_valid_o),
        .issue_pc_o          (issue_pc_o),
        .issue_inst_o        (issue_inst_o),
        .issue_exc_o         (issue_exc_o),
        .issue_is_branch_o   (issue_is_branch_o),
        .issue_pred_taken_o  (issue_pred_taken_o),
        .issue_pred_target_o (issue_pred_target_o),
        .issue_slot_valid_o  (issue_slot_valid_o)
    );

endmodule

/* inst_buffer_properties.sv */
`timescale 1ns/1ps

module inst_buffer_properties (
    input logic                                      clk,
    input logic                                      rst,
    input logic                                      stall_i,
    input logic [fe_pkg::LANES-1:0]                  issue_valid_i,
    input logic                                      fetch_ready_i,
    input logic [fe_pkg::LANES-1:0]                  push_i,
    input logic [fe_pkg::LANES-1:0][fe_pkg::PTR_W:0] free_slots_i
);

    // Stall holds decode off on every lane
    assert property (@(posedge clk) disable iff (rst) stall_i |-> !(|issue_valid_i))
        else $error("issue_valid_o high while stall_i is high");

    assert property (@(posedge clk) rst |-> !fetch_ready_i)
        else $error("fetch_ready_o high during reset");

    ////////////////////
    // Room for every push

    for (genvar b = 0; b < fe_pkg::LANES; b++) begin : gen_room
        assert property (@(posedge clk) disable iff (rst) push_i[b] |-> free_slots_i[b] != '0)
            else $error("push into bank %0d with no free slot", b);
    end

endmodule

bind inst_buffer_top inst_buffer_properties u_properties (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_i),
    .issue_valid_i (issue_valid_o),
    .fetch_ready_i (fetch_ready_o),
    .push_i        (push),
    .free_slots_i  (free_slots)
);

/* tb_inst_buffer.sv */
`timescale 1ns/1ps

module tb_inst_buffer;

    typedef struct packed {
        logic [fe_pkg::XLEN-1:0]  pc;
        logic [fe_pkg::XLEN-1:0]  inst;
        logic [fe_pkg::EXC_W-1:0] exc;
        logic                     is_branch;
        logic                     pred_taken;
        logic [fe_pkg::XLEN-1:0]  target;
        logic                     slot_valid;
    } entry_t;

    logic                                        clk;
    logic                                        rst;
    logic                                        flush_i;
    logic                                        stall_i;
    logic [fe_pkg::LANES-1:0]                    fetch_en_i;
    logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  pc_i;
    logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  inst_i;
    logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0] exc_i;
    logic [fe_pkg::LANES-1:0]                    is_branch_i;
    logic [fe_pkg::LANES-1:0]                    pred_taken_i;
    logic [fe_pkg::XLEN-1:0]                     pred_target_i;
    logic                                        fetch_ready_o;
    logic [fe_pkg::LANES-1:0]                    send_en_i;
    logic [fe_pkg::LANES-1:0]                    issue_valid_o;
    logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_pc_o;
    logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_inst_o;
    logic [fe_pkg::LANES-1:0][fe_pkg::EXC_W-1:0] issue_exc_o;
    logic [fe_pkg::LANES-1:0]                    issue_is_branch_o;
    logic [fe_pkg::LANES-1:0]                    issue_pred_taken_o;
    logic [fe_pkg::LANES-1:0][fe_pkg::XLEN-1:0]  issue_pred_target_o;
    logic [fe_pkg::LANES-1:0]                    issue_slot_valid_o;

    // Reference model of the two banks and the capture register
    entry_t                   model_q [fe_pkg::LANES][$];
    entry_t                   inflight [fe_pkg::LANES];
    logic [fe_pkg::LANES-1:0] inflight_v;
    logic                     model_shadow;
    logic                     model_live;
    logic                     last_ready;

    // Fetch-side stimulus controls
    logic                     offer_done;
    logic                     fetch_on;
    logic                     force_taken;
    int unsigned              branch_pct;
    int                       error_count;
    int                       shadow_seen;

    inst_buffer_top UUT (
        .clk                 (clk),
        .rst                 (rst),
        .flush_i             (flush_i),
        .stall_i             (stall_i),
        .fetch_en_i          (fetch_en_i),
        .pc_i                (pc_i),
        .inst_i              (inst_i),
        .exc_i               (exc_i),
        .is_branch_i         (is_branch_i),
        .pred_taken_i        (pred_taken_i),
        .pred_target_i       (pred_target_i),
        .fetch_ready_o       (fetch_ready_o),
        .send_en_i           (send_en_i),
        .issue_valid_o       (issue_valid_o),
        .issue_pc_o          (issue_pc_o),
        .issue_inst_o        (issue_inst_o),
        .issue_exc_o         (issue_exc_o),
        .issue_is_branch_o   (issue_is_branch_o),
        .issue_pred_taken_o  (issue_pred_taken_o),
        .issue_pred_target_o (issue_pred_target_o),
        .issue_slot_valid_o  (issue_slot_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Reporting

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout at %0t: %s", $time, what);
        abort_run();
    endtask

    ////////////////////
    // Stimulus

    function automatic logic [fe_pkg::LANES-1:0] rand_lanes();
        logic [31:0] r;
        r = $urandom;
        return r[fe_pkg::LANES-1:0];
    endfunction

    // A fresh fetch group, held by the caller until it is accepted
    task automatic new_offer();
        logic [31:0] r;
        r = $urandom;
        fetch_en_i    = fetch_on ? r[fe_pkg::LANES-1:0] : '0;
        pred_target_i = $urandom;
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            r = $urandom;
            pc_i[i]         = $urandom;
            inst_i[i]       = $urandom;
            exc_i[i]        = (r[4:2] == 3'd0) ? r[fe_pkg::EXC_W+4:5] : fe_pkg::EXC_NONE;
            is_branch_i[i]  = $urandom_range(0, 99) < branch_pct;
            pred_taken_i[i] = is_branch_i[i] & r[12];
        end
        if (force_taken && fetch_on) begin
            fetch_en_i[0]   = 1'b1;
            is_branch_i[0]  = 1'b1;
            pred_taken_i[0] = 1'b1;
        end
    endtask

    task automatic compare_head(input int i, input entry_t e);
        check_eq(issue_pc_o[i], e.pc, $sformatf("lane %0d pc", i));
        check_eq(issue_inst_o[i], e.inst, $sformatf("lane %0d inst", i));
        check_eq(32'(issue_exc_o[i]), 32'(e.exc), $sformatf("lane %0d exc", i));
        check_eq(32'(issue_is_branch_o[i]), 32'(e.is_branch), $sformatf("lane %0d branch", i));
        check_eq(32'(issue_pred_taken_o[i]), 32'(e.pred_taken), $sformatf("lane %0d taken", i));
        check_eq(issue_pred_target_o[i], e.target, $sformatf("lane %0d target", i));
        check_eq(32'(issue_slot_valid_o[i]), 32'(e.slot_valid),
                 $sformatf("lane %0d slot valid", i));
    endtask

    ////////////////////
    // Model step, evaluated just before each rising edge

    task automatic check_and_step();
        logic                     ready_exp;
        logic [fe_pkg::LANES-1:0] fire;
        logic [fe_pkg::LANES-1:0] accept;
        logic                     taken0;
        entry_t                   e;
        ready_exp = model_live;
        // Two free slots per bank, counting the entry in flight
        for (int b = 0; b < fe_pkg::LANES; b++) begin
            if (fe_pkg::DEPTH - model_q[b].size() - (inflight_v[b] ? 1 : 0) < 2) begin
                ready_exp = 1'b0;
            end
        end
        check_eq(32'(fetch_ready_o), 32'(ready_exp), "fetch_ready_o");
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            fire[i] = send_en_i[i] && !stall_i && (model_q[i].size() != 0);
            check_eq(32'(issue_valid_o[i]), 32'(fire[i]), $sformatf("lane %0d issue_valid", i));
            if (fire[i]) begin
                compare_head(i, model_q[i][0]);
                if (!model_q[i][0].slot_valid) begin
                    shadow_seen++;
                end
            end
        end
        accept = fetch_en_i & {fe_pkg::LANES{ready_exp && !stall_i && !flush_i}};
        model_live = 1'b1;
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            if (fire[i]) begin
                void'(model_q[i].pop_front());
            end
        end
        if (flush_i) begin
            for (int i = 0; i < fe_pkg::LANES; i++) begin
                model_q[i].delete();
            end
            inflight_v   = '0;
            model_shadow = 1'b0;
            offer_done   = 1'b1;
        end else begin
            for (int i = 0; i < fe_pkg::LANES; i++) begin
                if (inflight_v[i]) begin
                    model_q[i].push_back(inflight[i]);
                end
            end
            taken0 = accept[0] & is_branch_i[0] & pred_taken_i[0];
            for (int i = 0; i < fe_pkg::LANES; i++) begin
                e.pc         = pc_i[i];
                e.inst       = inst_i[i];
                e.exc        = exc_i[i];
                e.is_branch  = is_branch_i[i];
                e.pred_taken = pred_taken_i[i];
                e.target     = pred_target_i;
                // Wrong path behind the last group or behind a taken lane 0
                e.slot_valid = !(model_shadow || (i == 1 && taken0));
                inflight[i]  = e;
            end
            inflight_v = accept;
            if (|accept) begin
                model_shadow = |(accept & is_branch_i & pred_taken_i);
            end
            offer_done = (|accept) || (fetch_en_i == '0);
        end
        last_ready = ready_exp;
    endtask

    task automatic run_cycle(input logic [fe_pkg::LANES-1:0] send, input logic stall,
                             input logic flush);
        @(negedge clk);
        rst = 1'b0;
        if (offer_done) begin
            new_offer();
        end
        send_en_i = send;
        stall_i   = stall;
        flush_i   = flush;
        #1;
        check_and_step();
    endtask

    function automatic bit model_idle();
        for (int i = 0; i < fe_pkg::LANES; i++) begin
            if (model_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return (inflight_v == '0) && offer_done;
    endfunction

    task automatic drain(input string phase);
        int waited;
        waited   = 0;
        fetch_on = 1'b0;
        while (!model_idle()) begin
            run_cycle('1, 1'b0, 1'b0);
            waited++;
            if (waited > 100) begin
                timed_out({"banks did not drain after the ", phase, " phase"});
            end
        end
        repeat (3) run_cycle('1, 1'b0, 1'b0);
        fetch_on = 1'b1;
    endtask

    ////////////////////
    // Test sequence

    initial begin
        int waited;
        void'($urandom(14));
        rst           = 1'b1;
        flush_i       = 1'b0;
        stall_i       = 1'b0;
        fetch_en_i    = '0;
        pc_i          = '0;
        inst_i        = '0;
        exc_i         = '0;
        is_branch_i   = '0;
        pred_taken_i  = '0;
        pred_target_i = '0;
        send_en_i     = '0;
        inflight_v    = '0;
        model_shadow  = 1'b0;
        model_live    = 1'b0;
        last_ready    = 1'b0;
        offer_done    = 1'b1;
        fetch_on      = 1'b1;
        force_taken   = 1'b0;
        branch_pct    = 10;
        error_count   = 0;
        shadow_seen   = 0;

        repeat (8) begin
            @(posedge clk);
            #1;
            check_eq(32'(fetch_ready_o), 32'd0, "fetch_ready_o in reset");
            check_eq(32'(issue_valid_o), 32'd0, "issue_valid_o in reset");
        end

        // Order and integrity
        repeat (200) run_cycle('1, 1'b0, 1'b0);
        drain("order");

        // Branch shadow
        branch_pct  = 40;
        shadow_seen = 0;
        repeat (200) run_cycle('1, 1'b0, 1'b0);
        drain("shadow");
        if (shadow_seen == 0) begin
            $display("No wrong-path entry was issued in the shadow phase");
            abort_run();
        end

        // Back-pressure with decode stopped
        waited = 0;
        while (last_ready) begin
            run_cycle('0, 1'b0, 1'b0);
            waited++;
            if (waited > 200) begin
                timed_out("fetch_ready_o never fell with decode stopped");
            end
        end
        repeat (10) run_cycle('0, 1'b0, 1'b0);
        drain("back-pressure");

        // Stall pulses
        repeat (200) run_cycle('1, $urandom_range(0, 3) == 0, 1'b0);
        drain("stall");

        // Flush with a taken branch in the group history
        repeat (40) run_cycle(rand_lanes(), 1'b0, 1'b0);
        force_taken = 1'b1;
        waited      = 0;
        while (!model_shadow) begin
            run_cycle(rand_lanes(), 1'b0, 1'b0);
            waited++;
            if (waited > 100) begin
                timed_out("no taken branch was accepted before the flush");
            end
        end
        force_taken = 1'b0;
        run_cycle('0, 1'b0, 1'b1);
        repeat (60) run_cycle(rand_lanes(), 1'b0, 1'b0);
        drain("flush");

        // Independent lanes
        repeat (300) run_cycle(rand_lanes(), 1'b0, 1'b0);
        drain("independent lanes");

        if (error_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* flist.f */
fe_pkg.sv
fetch_capture.sv
inst_fifo.sv
issue_select.sv
inst_buffer_top.sv
inst_buffer_properties.sv
tb_inst_buffer.sv

/* run.sh */
#!/bin/sh
# Build and run the instruction buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_inst_buffer -f flist.f

out=$(./obj_dir/Vtb_inst_buffer 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
